// ==== design/ntt_bfly_pkg.sv ====
// widths, modulus, Barrett constants, latencies, mode type and lane-wise modular helpers
`default_nettype none

package ntt_bfly_pkg;

    // lane and operand geometry
    localparam int LANE_W = 16;
    localparam int LANES  = 8;
    localparam int DATA_W = LANE_W * LANES;

    // Falcon modulus
    localparam int Q = 12289;

    // Barrett reduction, valid for products below 2^BARRETT_K
    // q*q is about 1.51e8, under 2^28
    localparam int BARRETT_K = 28;
    localparam int BARRETT_M = (1 << BARRETT_K) / Q;

    // pipeline depths in clock cycles
    localparam int MUL_LATENCY  = 3;
    // accept edge to o_vld, including the issue register
    localparam int PIPE_LATENCY = 6;

    typedef logic [LANE_W-1:0] lane_t;
    typedef logic [DATA_W-1:0] data_t;

    // low bit of the old 2-bit mode field: NTT=10, iNTT=11
    typedef enum logic {
        MODE_NTT  = 1'b0,
        MODE_INTT = 1'b1
    } bfly_mode_t;

    // (x + y) mod q, both inputs below q
    // sum stays under 2q, so 16 bits never overflow
    function automatic lane_t mod_add(lane_t x, lane_t y);
        lane_t s;
        s = x + y;
        if (s >= lane_t'(Q)) begin
            s = s - lane_t'(Q);
        end
        return s;
    endfunction

    // (x - y) mod q, both inputs below q
    // a borrow wraps mod 2^16, adding q brings it back into range
    function automatic lane_t mod_sub(lane_t x, lane_t y);
        lane_t d;
        d = x - y;
        if (x < y) begin
            d = d + lane_t'(Q);
        end
        return d;
    endfunction

    // x/2 mod q; odd values borrow one q first
    function automatic lane_t mod_half(lane_t x);
        lane_t h;
        if (x[0]) begin
            h = (x + lane_t'(Q)) >> 1;
        end else begin
            h = x >> 1;
        end
        return h;
    endfunction

endpackage

`default_nettype wire

// ==== design/bfly_issue_if.sv ====
// issue bundle from the controller to the lanes and the valid delay line
`default_nettype none

interface bfly_issue_if;

    // one-cycle strobe per accepted butterfly
    logic                     vld;
    // current mode, stable while anything is in flight
    ntt_bfly_pkg::bfly_mode_t mode;
    // registered operands, all eight lanes packed
    ntt_bfly_pkg::data_t      a;
    ntt_bfly_pkg::data_t      b;
    ntt_bfly_pkg::data_t      g;

    // controller side
    modport src (
        output vld,
        output mode,
        output a,
        output b,
        output g
    );

    // lanes and valid delay line
    modport snk (
        input vld,
        input mode,
        input a,
        input b,
        input g
    );

endinterface

`default_nettype wire

// ==== design/delay_line.sv ====
// reset-cleared shift register of any payload type, aligns data with the pipeline
`default_nettype none

module delay_line #(
    parameter int  DEPTH = 1,
    parameter type T     = logic
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire T i_d,
    output T     o_q
);

    // stage 0 takes the input, last stage drives the output
    T stages [DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= T'(0);
            end
        end else begin
            stages[0] <= i_d;
            // shift towards the output
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign o_q = stages[DEPTH-1];

endmodule

`default_nettype wire

// ==== design/mod_mul.sv ====
// three-stage lane multiplier mod q with Barrett reduction
`default_nettype none

module mod_mul (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire ntt_bfly_pkg::lane_t i_x,
    input  wire ntt_bfly_pkg::lane_t i_y,
    output ntt_bfly_pkg::lane_t      o_p
);

    // product of two values below q fits in BARRETT_K bits
    localparam int PROD_W = ntt_bfly_pkg::BARRETT_K;
    // product times m, shifted right by k leaves a lane-wide quotient
    localparam int EST_W  = ntt_bfly_pkg::BARRETT_K + ntt_bfly_pkg::LANE_W;

    localparam logic [PROD_W-1:0] Q_P   = PROD_W'(ntt_bfly_pkg::Q);
    localparam logic [PROD_W-1:0] Q2_P  = PROD_W'(2 * ntt_bfly_pkg::Q);
    localparam logic [EST_W-1:0]  M_EST = EST_W'(ntt_bfly_pkg::BARRETT_M);

    logic [PROD_W-1:0]   x_ext;
    logic [PROD_W-1:0]   y_ext;
    logic [PROD_W-1:0]   prod_s1;
    logic [PROD_W-1:0]   prod_s2;
    logic [EST_W-1:0]    est;
    ntt_bfly_pkg::lane_t qhat_s2;
    logic [PROD_W-1:0]   rem;
    logic [PROD_W-1:0]   rem_fix;

    assign x_ext = PROD_W'(i_x);
    assign y_ext = PROD_W'(i_y);

    // quotient estimate, undershoots the true quotient by at most 2
    assign est = EST_W'(prod_s1) * M_EST;

    // remainder lands in [0, 3q)
    always_comb begin
        rem = prod_s2 - PROD_W'(qhat_s2) * Q_P;
        if (rem >= Q2_P) begin
            rem_fix = rem - Q2_P;
        end else if (rem >= Q_P) begin
            rem_fix = rem - Q_P;
        end else begin
            rem_fix = rem;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_s1 <= '0;
            prod_s2 <= '0;
            qhat_s2 <= '0;
            o_p     <= '0;
        end else begin
            // stage 1: raw product
            prod_s1 <= x_ext * y_ext;
            // stage 2: quotient estimate, product carried alongside
            qhat_s2 <= ntt_bfly_pkg::LANE_W'(est >> ntt_bfly_pkg::BARRETT_K);
            prod_s2 <= prod_s1;
            // stage 3: corrected remainder, below q
            o_p     <= ntt_bfly_pkg::LANE_W'(rem_fix);
        end
    end

endmodule

`default_nettype wire

// ==== design/bfly_lane.sv ====
// one 16-bit lane, Cooley-Tukey (NTT) or Gentleman-Sande (iNTT) butterfly with output register
`default_nettype none

module bfly_lane #(
    parameter int LANE = 0
) (
    input  wire                 clk,
    input  wire                 rst_n,
    bfly_issue_if.snk           issue,
    output ntt_bfly_pkg::lane_t o_a,
    output ntt_bfly_pkg::lane_t o_b
);

    localparam int LSB = LANE * ntt_bfly_pkg::LANE_W;

    ntt_bfly_pkg::lane_t a_in;
    ntt_bfly_pkg::lane_t b_in;
    ntt_bfly_pkg::lane_t g_in;
    ntt_bfly_pkg::lane_t g_dly;
    ntt_bfly_pkg::lane_t as_x;
    ntt_bfly_pkg::lane_t as_y;
    ntt_bfly_pkg::lane_t as_sum_r;
    ntt_bfly_pkg::lane_t as_diff_r;
    ntt_bfly_pkg::lane_t mul_x;
    ntt_bfly_pkg::lane_t mul_y;
    ntt_bfly_pkg::lane_t mul_p;
    ntt_bfly_pkg::lane_t comp_d;
    ntt_bfly_pkg::lane_t comp_q;
    logic                is_intt;

    // mode is frozen while items are in flight
    assign is_intt = (issue.mode == ntt_bfly_pkg::MODE_INTT);

    assign a_in = issue.a[LSB +: ntt_bfly_pkg::LANE_W];
    assign b_in = issue.b[LSB +: ntt_bfly_pkg::LANE_W];
    assign g_in = issue.g[LSB +: ntt_bfly_pkg::LANE_W];

    // shared add/sub register
    // iNTT uses it first (a, b), NTT uses it after the multiplier
    assign as_x = is_intt ? a_in : comp_q;
    assign as_y = is_intt ? b_in : mul_p;

    always_ff @(posedge clk) begin
        as_sum_r  <= ntt_bfly_pkg::mod_add(as_x, as_y);
        as_diff_r <= ntt_bfly_pkg::mod_sub(as_x, as_y);
    end

    // twiddle one cycle late, lines up with the iNTT difference
    delay_line #(
        .DEPTH (1),
        .T     (ntt_bfly_pkg::lane_t)
    ) u_g_dly (
        .clk   (clk),
        .rst_n (rst_n),
        .i_d   (g_in),
        .o_q   (g_dly)
    );

    // NTT: b*g straight from issue
    // iNTT: (a-b)*g one stage later
    assign mul_x = is_intt ? as_diff_r : b_in;
    assign mul_y = is_intt ? g_dly : g_in;

    mod_mul u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .i_x   (mul_x),
        .i_y   (mul_y),
        .o_p   (mul_p)
    );

    // companion operand rides beside the multiplier
    // a for NTT, a+b for iNTT
    assign comp_d = is_intt ? as_sum_r : a_in;

    delay_line #(
        .DEPTH (ntt_bfly_pkg::MUL_LATENCY),
        .T     (ntt_bfly_pkg::lane_t)
    ) u_comp_dly (
        .clk   (clk),
        .rst_n (rst_n),
        .i_d   (comp_d),
        .o_q   (comp_q)
    );

    // output register, fifth cycle after issue in both modes
    always_ff @(posedge clk) begin
        if (is_intt) begin
            // (a+b)/2 and ((a-b)*g)/2
            o_a <= ntt_bfly_pkg::mod_half(comp_q);
            o_b <= ntt_bfly_pkg::mod_half(mul_p);
        end else begin
            // a+b*g and a-b*g from the add/sub register
            o_a <= as_sum_r;
            o_b <= as_diff_r;
        end
    end

endmodule

`default_nettype wire

// ==== design/bfly_ctrl.sv ====
// input handshake, mode-switch drain FSM, since-accept counter and operand buffer
`default_nettype none

module bfly_ctrl (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             i_vld,
    input  wire ntt_bfly_pkg::bfly_mode_t   i_mode,
    input  wire ntt_bfly_pkg::data_t        i_a,
    input  wire ntt_bfly_pkg::data_t        i_b,
    input  wire ntt_bfly_pkg::data_t        i_g,
    output logic                            o_rdy,
    bfly_issue_if.src                       issue
);

    // counter must reach PIPE_LATENCY and hold there
    localparam int               CNT_W   = $clog2(ntt_bfly_pkg::PIPE_LATENCY + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(ntt_bfly_pkg::PIPE_LATENCY);

    typedef enum logic {
        ST_READY,
        ST_DRAIN
    } state_t;

    state_t                   state;
    state_t                   state_next;
    logic [CNT_W-1:0]         cnt;
    ntt_bfly_pkg::bfly_mode_t mode_r;
    logic                     mode_diff;
    logic                     drained;
    logic                     accept;

    assign mode_diff = (i_mode != mode_r);
    // nothing left in the pipeline once cnt saturates
    assign drained   = (cnt == CNT_MAX);

    // stall as soon as a request asks for the other mode
    assign o_rdy  = (state == ST_READY) && !(i_vld && mode_diff);
    assign accept = i_vld && o_rdy;

    // READY -> DRAIN on a mode request, back once the pipe is empty
    always_comb begin
        state_next = state;
        case (state)
            ST_READY: begin
                if (i_vld && mode_diff) begin
                    state_next = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                if (drained) begin
                    state_next = ST_READY;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_READY;
        end else begin
            state <= state_next;
        end
    end

    // cycles since the last accept, starts out saturated (empty pipe)
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= CNT_MAX;
        end else if (accept) begin
            cnt <= '0;
        end else if (!drained) begin
            cnt <= cnt + 1'b1;
        end
    end

    // mode only moves at the end of a drain
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_r <= ntt_bfly_pkg::MODE_NTT;
        end else if (state == ST_DRAIN && drained) begin
            mode_r <= i_mode;
        end
    end

    assign issue.mode = mode_r;

    // issue strobe, one cycle after the accepting edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue.vld <= 1'b0;
        end else begin
            issue.vld <= accept;
        end
    end

    // operand buffer, loaded only on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            issue.a <= i_a;
            issue.b <= i_b;
            issue.g <= i_g;
        end
    end

endmodule

`default_nettype wire

// ==== design/ntt_butterfly.sv ====
// top level: controller, eight butterfly lanes and output valid delay
`default_nettype none

module ntt_butterfly (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             i_vld,
    output wire                             i_rdy,
    input  wire ntt_bfly_pkg::bfly_mode_t   i_mode,
    input  wire ntt_bfly_pkg::data_t        i_a,
    input  wire ntt_bfly_pkg::data_t        i_b,
    input  wire ntt_bfly_pkg::data_t        i_g,
    output wire                             o_vld,
    output wire ntt_bfly_pkg::data_t        o_a,
    output wire ntt_bfly_pkg::data_t        o_b
);

    // accepted butterflies, controller to lanes
    bfly_issue_if u_issue ();

    // handshake, drain on mode change, operand buffer
    bfly_ctrl u_ctrl (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_vld  (i_vld),
        .i_mode (i_mode),
        .i_a    (i_a),
        .i_b    (i_b),
        .i_g    (i_g),
        .o_rdy  (i_rdy),
        .issue  (u_issue.src)
    );

    // one datapath per 16-bit lane
    for (genvar i = 0; i < ntt_bfly_pkg::LANES; i++) begin : g_lane
        bfly_lane #(
            .LANE  (i)
        ) u_lane (
            .clk   (clk),
            .rst_n (rst_n),
            .issue (u_issue.snk),
            .o_a   (o_a[i*ntt_bfly_pkg::LANE_W +: ntt_bfly_pkg::LANE_W]),
            .o_b   (o_b[i*ntt_bfly_pkg::LANE_W +: ntt_bfly_pkg::LANE_W])
        );
    end

    // issue strobe is already one cycle past the accept
    // the rest of the pipeline depth is made up here
    delay_line #(
        .DEPTH (ntt_bfly_pkg::PIPE_LATENCY - 1),
        .T     (logic)
    ) u_vld_dly (
        .clk   (clk),
        .rst_n (rst_n),
        .i_d   (u_issue.vld),
        .o_q   (o_vld)
    );

endmodule

`default_nettype wire

// ==== bench/ntt_butterfly_chk.sv ====
// bound checks on the top ports: quiet after reset, lane range, fixed accept-to-result latency
`default_nettype none

module ntt_butterfly_chk (
    input wire                      clk,
    input wire                      rst_n,
    input wire                      i_vld,
    input wire                      i_rdy,
    input wire                      o_vld,
    input wire ntt_bfly_pkg::data_t o_a,
    input wire ntt_bfly_pkg::data_t o_b
);

    localparam int LAT = ntt_bfly_pkg::PIPE_LATENCY;
    localparam int LW  = ntt_bfly_pkg::LANE_W;

    logic accept;

    assign accept = i_vld && i_rdy;

    // every lane of an operand below q
    function automatic logic lanes_below_q(ntt_bfly_pkg::data_t d);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < ntt_bfly_pkg::LANES; i++) begin
            if (int'(d[i*LW +: LW]) >= ntt_bfly_pkg::Q) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // no result before a full pipeline depth out of reset
    a_quiet_after_reset: assert property (
        @(posedge clk) disable iff (!rst_n) o_vld |-> $past(rst_n, LAT)
    ) else $error("o_vld high within %0d cycles of reset release", LAT);

    a_lanes_in_range: assert property (
        @(posedge clk) disable iff (!rst_n) o_vld |-> (lanes_below_q(o_a) && lanes_below_q(o_b))
    ) else $error("output lane not below q");

    // every accept comes out exactly LAT cycles later
    a_accept_to_result: assert property (
        @(posedge clk) disable iff (!rst_n) accept |-> ##LAT o_vld
    ) else $error("o_vld missing %0d cycles after an accept", LAT);

    // and nothing comes out without one
    a_result_has_accept: assert property (
        @(posedge clk) disable iff (!rst_n) o_vld |-> $past(accept, LAT)
    ) else $error("o_vld without an accept %0d cycles earlier", LAT);

endmodule

`default_nettype wire

// ==== bench/tb_ntt_butterfly.sv ====
// testbench: clock, reset, stimulus, reference model, scoreboard and summary
`default_nettype none

module tb_ntt_butterfly;

    localparam int LW  = ntt_bfly_pkg::LANE_W;
    localparam int NL  = ntt_bfly_pkg::LANES;
    localparam int Q   = ntt_bfly_pkg::Q;
    localparam int LAT = ntt_bfly_pkg::PIPE_LATENCY;
    // longest any single wait may take, in cycles
    localparam int WAIT_LIMIT = 100;
    localparam int NE         = 6;

    // edge operand table, lane i of item c takes entry (c + i) mod NE
    localparam int EDGE_A [NE] = '{0, Q-1, 0, Q-1, 6144, 1};
    localparam int EDGE_B [NE] = '{0, Q-1, Q-1, 1, 6144, 2};
    localparam int EDGE_G [NE] = '{0, Q-1, 1, 1, 5, Q-1};

    logic                     clk;
    logic                     rst_n;
    logic                     i_vld;
    logic                     i_rdy;
    ntt_bfly_pkg::bfly_mode_t i_mode;
    ntt_bfly_pkg::data_t      i_a;
    ntt_bfly_pkg::data_t      i_b;
    ntt_bfly_pkg::data_t      i_g;
    logic                     o_vld;
    ntt_bfly_pkg::data_t      o_a;
    ntt_bfly_pkg::data_t      o_b;

    // expected {o_a, o_b} and accept cycle of every item in flight
    logic [2*ntt_bfly_pkg::DATA_W-1:0] exp_q[$];
    int                                acc_cyc_q[$];
    int                                cyc;
    int                                n_accept;
    int                                n_result;
    int                                n_checks;
    int                                val_errs;
    int                                other_errs;
    integer                            seed;

    ntt_butterfly u_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_vld  (i_vld),
        .i_rdy  (i_rdy),
        .i_mode (i_mode),
        .i_a    (i_a),
        .i_b    (i_b),
        .i_g    (i_g),
        .o_vld  (o_vld),
        .o_a    (o_a),
        .o_b    (o_b)
    );

    bind ntt_butterfly ntt_butterfly_chk u_chk (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_vld  (i_vld),
        .i_rdy  (i_rdy),
        .o_vld  (o_vld),
        .o_a    (o_a),
        .o_b    (o_b)
    );

    always #50 clk = ~clk;

    // x/2 mod q, odd x borrows one q first
    function automatic int half_q(int x);
        if (x % 2 == 1) begin
            return (x + Q) / 2;
        end else begin
            return x / 2;
        end
    endfunction

    // expected {o_a, o_b}, lane by lane from the butterfly rules
    function automatic logic [2*ntt_bfly_pkg::DATA_W-1:0] bfly_expect(
        ntt_bfly_pkg::bfly_mode_t m,
        ntt_bfly_pkg::data_t      a,
        ntt_bfly_pkg::data_t      b,
        ntt_bfly_pkg::data_t      g
    );
        ntt_bfly_pkg::data_t ea;
        ntt_bfly_pkg::data_t eb;
        int                  av;
        int                  bv;
        int                  gv;
        int                  t;
        ea = '0;
        eb = '0;
        for (int i = 0; i < NL; i++) begin
            av = int'(a[i*LW +: LW]);
            bv = int'(b[i*LW +: LW]);
            gv = int'(g[i*LW +: LW]);
            if (m == ntt_bfly_pkg::MODE_NTT) begin
                // Cooley-Tukey: a +/- b*g
                t = (bv * gv) % Q;
                ea[i*LW +: LW] = ntt_bfly_pkg::lane_t'((av + t) % Q);
                eb[i*LW +: LW] = ntt_bfly_pkg::lane_t'((av - t + Q) % Q);
            end else begin
                // Gentleman-Sande, both outputs halved
                t = (((av - bv + Q) % Q) * gv) % Q;
                ea[i*LW +: LW] = ntt_bfly_pkg::lane_t'(half_q((av + bv) % Q));
                eb[i*LW +: LW] = ntt_bfly_pkg::lane_t'(half_q(t));
            end
        end
        return {ea, eb};
    endfunction

    // eight random lanes, each below q
    function automatic ntt_bfly_pkg::data_t rand_operand();
        ntt_bfly_pkg::data_t d;
        for (int i = 0; i < NL; i++) begin
            d[i*LW +: LW] = ntt_bfly_pkg::lane_t'($unsigned($random(seed)) % Q);
        end
        return d;
    endfunction

    task automatic print_summary();
        $display("summary: accepts %0d, results %0d, checks %0d, value errors %0d, other %0d",
                 n_accept, n_result, n_checks, val_errs, other_errs);
    endtask

    task automatic report_timeout(input string what);
        other_errs++;
        $display("timeout at %0t: %s", $time, what);
        print_summary();
        $display("TEST FAILED");
    endtask

    // scoreboard: result check first, then record this edge's accept
    always @(posedge clk) begin
        logic [2*ntt_bfly_pkg::DATA_W-1:0] exp_v;
        int                                lat;
        if (rst_n) begin
            if (o_vld) begin
                n_result++;
                if (exp_q.size() == 0) begin
                    other_errs++;
                    $display("unexpected o_vld at %0t with nothing in flight", $time);
                end else begin
                    exp_v = exp_q.pop_front();
                    lat   = cyc - acc_cyc_q.pop_front();
                    n_checks++;
                    if ({o_a, o_b} !== exp_v) begin
                        val_errs++;
                        $display("[FAIL] %0t: o_a %h o_b %h, expected o_a %h o_b %h", $time,
                                 o_a, o_b, exp_v[2*ntt_bfly_pkg::DATA_W-1 -: ntt_bfly_pkg::DATA_W],
                                 exp_v[ntt_bfly_pkg::DATA_W-1:0]);
                    end
                    if (lat != LAT) begin
                        val_errs++;
                        $display("[FAIL] %0t: latency %0d, expected %0d", $time, lat, LAT);
                    end
                end
            end
            if (i_vld && i_rdy) begin
                exp_q.push_back(bfly_expect(i_mode, i_a, i_b, i_g));
                acc_cyc_q.push_back(cyc);
                n_accept++;
            end
        end
        cyc++;
    end

    // called at a falling edge, holds the item until the DUT takes it
    task automatic send_item(
        input  ntt_bfly_pkg::bfly_mode_t m,
        input  ntt_bfly_pkg::data_t      a,
        input  ntt_bfly_pkg::data_t      b,
        input  ntt_bfly_pkg::data_t      g,
        output int                       stalls
    );
        int start;
        start  = n_accept;
        stalls = 0;
        i_vld  = 1'b1;
        i_mode = m;
        i_a    = a;
        i_b    = b;
        i_g    = g;
        @(negedge clk);
        while (n_accept == start) begin
            stalls++;
            if (stalls > WAIT_LIMIT) begin
                report_timeout("item never accepted, i_rdy stuck low");
                $finish;
            end
            @(negedge clk);
        end
    endtask

    task automatic send_random(input ntt_bfly_pkg::bfly_mode_t m, output int stalls);
        ntt_bfly_pkg::data_t ra;
        ntt_bfly_pkg::data_t rb;
        ntt_bfly_pkg::data_t rg;
        ra = rand_operand();
        rb = rand_operand();
        rg = rand_operand();
        send_item(m, ra, rb, rg, stalls);
    endtask

    task automatic idle(input int n);
        i_vld = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    // wait for the scoreboard to empty, then watch for stray o_vld
    task automatic wait_empty();
        int waited;
        waited = 0;
        i_vld  = 1'b0;
        while (exp_q.size() != 0) begin
            if (waited > WAIT_LIMIT) begin
                report_timeout("results still missing after the last accept");
                $finish;
            end
            @(negedge clk);
            waited++;
        end
        repeat (LAT + 2) @(negedge clk);
    endtask

    initial begin
        int                       st;
        int                       gap;
        ntt_bfly_pkg::bfly_mode_t m;
        ntt_bfly_pkg::data_t      ea;
        ntt_bfly_pkg::data_t      eb;
        ntt_bfly_pkg::data_t      eg;
        seed       = 32'h58ec_6cc1;
        clk        = 1'b0;
        rst_n      = 1'b0;
        i_vld      = 1'b0;
        i_mode     = ntt_bfly_pkg::MODE_NTT;
        i_a        = '0;
        i_b        = '0;
        i_g        = '0;
        cyc        = 0;
        n_accept   = 0;
        n_result   = 0;
        n_checks   = 0;
        val_errs   = 0;
        other_errs = 0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        // back-to-back NTT, no stall expected
        for (int k = 0; k < 20; k++) begin
            send_random(ntt_bfly_pkg::MODE_NTT, st);
            if (st != 0) begin
                other_errs++;
                $display("i_rdy dropped during back-to-back NTT items at %0t", $time);
            end
        end
        // iNTT right behind the NTT items, first one must stall for the drain
        for (int k = 0; k < 20; k++) begin
            send_random(ntt_bfly_pkg::MODE_INTT, st);
            if ((k == 0) != (st != 0)) begin
                other_errs++;
                $display("i_rdy wrong around the switch to iNTT at %0t, item %0d", $time, k);
            end
        end
        // and back to NTT with iNTT still in flight
        send_random(ntt_bfly_pkg::MODE_NTT, st);
        if (st == 0) begin
            other_errs++;
            $display("i_rdy stayed high across the switch to NTT at %0t", $time);
        end

        // edge operands in both modes
        for (int mi = 0; mi < 2; mi++) begin
            m = (mi == 0) ? ntt_bfly_pkg::MODE_NTT : ntt_bfly_pkg::MODE_INTT;
            for (int c = 0; c < NE; c++) begin
                for (int i = 0; i < NL; i++) begin
                    ea[i*LW +: LW] = ntt_bfly_pkg::lane_t'(EDGE_A[(c + i) % NE]);
                    eb[i*LW +: LW] = ntt_bfly_pkg::lane_t'(EDGE_B[(c + i) % NE]);
                    eg[i*LW +: LW] = ntt_bfly_pkg::lane_t'(EDGE_G[(c + i) % NE]);
                end
                send_item(m, ea, eb, eg, st);
            end
        end

        // random gaps and random mode changes
        m = ntt_bfly_pkg::MODE_NTT;
        for (int k = 0; k < 200; k++) begin
            if (($random(seed) & 7) == 0) begin
                m = (m == ntt_bfly_pkg::MODE_NTT) ? ntt_bfly_pkg::MODE_INTT : ntt_bfly_pkg::MODE_NTT;
            end
            gap = $unsigned($random(seed)) % 4;
            if (gap != 0) begin
                idle(gap);
            end
            send_random(m, st);
        end
        wait_empty();

        if (n_result != n_accept) begin
            val_errs++;
            $display("[FAIL] %0t: %0d o_vld pulses for %0d accepts", $time, n_result, n_accept);
        end
        print_summary();
        if (val_errs == 0 && other_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
design/ntt_bfly_pkg.sv
design/bfly_issue_if.sv
design/delay_line.sv
design/mod_mul.sv
design/bfly_lane.sv
design/bfly_ctrl.sv
design/ntt_butterfly.sv
bench/ntt_butterfly_chk.sv
bench/tb_ntt_butterfly.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_ntt_butterfly
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, an aborted run has no pass line
run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
